/* Bender.yml */
package:
  name: core_backend

sources:
  - core_pkg.sv
  - alu.sv
  - branch_unit.sv
  - ex_mem_reg.sv
  - mem_access.sv
  - core_backend.sv
  - target: simulation
    files:
      - tb_wb_memory.sv
      - tb_core_backend.sv

/* alu.sv */
`timescale 1ns/1ns

module alu import core_pkg::*; (
    input  ex_issue_t issue,
    output word_t     alu_res
);

    word_t      imm_sext;
    word_t      imm_zext;
    word_t      op_a;
    word_t      op_b;
    logic       logical_op;
    logic [4:0] shamt;

    assign imm_sext = {{16{issue.imm16[15]}}, issue.imm16};
    assign imm_zext = {16'h0000, issue.imm16};

    // andi, ori and xori take the immediate zero-extended.
    assign logical_op = (issue.alu_op == alu_and) ||
                        (issue.alu_op == alu_or)  ||
                        (issue.alu_op == alu_xor);

    assign op_a  = issue.data_a;
    assign op_b  = issue.use_imm ? (logical_op ? imm_zext : imm_sext) : issue.data_b;
    assign shamt = issue.imm16[10:6];

    always_comb begin
        case (issue.alu_op)
            alu_add: begin
                // Also the effective address of loads and stores.
                alu_res = op_a + op_b;
            end
            alu_sub: begin
                alu_res = op_a - op_b;
            end
            alu_and:  alu_res = op_a & op_b;
            alu_or:   alu_res = op_a | op_b;
            alu_xor:  alu_res = op_a ^ op_b;
            alu_slt: begin
                alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            end
            alu_sltu: begin
                alu_res = {31'd0, op_a < op_b};
            end
            // Shifts act on rt with the shamt field.
            alu_sll:  alu_res = issue.data_b << shamt;
            alu_srl:  alu_res = issue.data_b >> shamt;
            alu_sra: begin
                alu_res = word_t'($signed(issue.data_b) >>> shamt);
            end
            alu_lui: begin
                alu_res = {issue.imm16, 16'h0000};
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

endmodule

/* branch_unit.sv */
`timescale 1ns/1ns

module branch_unit import core_pkg::*; (
    input  ex_issue_t issue,
    output logic      taken,
    output pc_t       target,
    output logic      mispredict
);

    pc_t br_off;
    pc_t next_pc;

    assign br_off = {{14{issue.imm16[15]}}, issue.imm16, 2'b00};

    always_comb begin
        taken  = 1'b0;
        target = issue.pc_4;
        case (issue.br_op)
            br_beq: begin
                taken  = (issue.data_a == issue.data_b);
                target = issue.pc_4 + br_off;
            end
            br_bne: begin
                taken  = (issue.data_a != issue.data_b);
                target = issue.pc_4 + br_off;
            end
            br_blez: begin
                taken  = ($signed(issue.data_a) <= 0);
                target = issue.pc_4 + br_off;
            end
            br_bgtz: begin
                taken  = ($signed(issue.data_a) > 0);
                target = issue.pc_4 + br_off;
            end
            br_j: begin
                taken  = 1'b1;
                target = {issue.pc_4[31:28], 10'd0, issue.imm16, 2'b00};
            end
            br_jr: begin
                taken  = 1'b1;
                target = issue.data_a;
            end
            default: begin
                taken  = 1'b0;
            end
        endcase
    end

    // Non-branches fall through to pc_4.
    assign next_pc    = taken ? target : issue.pc_4;
    assign mispredict = (next_pc != issue.pc_guessed);

    always_comb begin
        assert final (issue.br_op != br_none || !taken)
            else $error("branch_unit: taken raised for a non-branch");
    end

endmodule

/* core_backend.sv */
`timescale 1ns/1ns

module core_backend import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       issue_valid,
    input  ex_issue_t  issue,
    output logic       issue_ready,
    input  logic       flush,
    output logic       redirect,
    output pc_t        redirect_pc,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output logic [3:0] wb_sel,
    output pc_t        wb_adr,
    output word_t      wb_dat_w,
    input  word_t      wb_dat_r,
    input  logic       wb_ack,
    output wb_t        wb_out
);

    word_t   alu_res;
    logic    br_taken;
    pc_t     br_target;
    logic    br_mispredict;
    ex_mem_t staged;
    logic    mem_busy;
    logic    issue_fire;

    // The back end stalls the issue stage while a memory access is in flight.
    assign issue_ready = !mem_busy;
    assign issue_fire  = issue_valid && issue_ready;
    assign redirect    = staged.redirect;
    assign redirect_pc = staged.redirect_pc;

    alu alu_i (
        .issue   (issue),
        .alu_res (alu_res)
    );

    branch_unit branch_unit_i (
        .issue      (issue),
        .taken      (br_taken),
        .target     (br_target),
        .mispredict (br_mispredict)
    );

    ex_mem_reg ex_mem_reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (issue_ready),
        .flush      (flush),
        .issue_fire (issue_fire),
        .issue      (issue),
        .alu_res    (alu_res),
        .mispredict (br_mispredict),
        .target_pc  (br_taken ? br_target : issue.pc_4),
        .staged     (staged)
    );

    mem_access mem_access_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .staged   (staged),
        .busy     (mem_busy),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_sel   (wb_sel),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_out   (wb_out)
    );

endmodule

/* core_pkg.sv */
package core_pkg;

    localparam int addr_w    = 32;
    localparam int word_w    = 32;
    localparam int reg_idx_w = 5;
    localparam int imm_w     = 16;

    typedef logic [addr_w-1:0]    pc_t;
    typedef logic [word_w-1:0]    word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [imm_w-1:0]     imm16_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blez,
        br_bgtz,
        br_j,
        br_jr
    } br_op_e;

    // Loads come before stores.
    typedef enum logic [3:0] {
        dm_none,
        dm_lb,
        dm_lbu,
        dm_lh,
        dm_lhu,
        dm_lw,
        dm_sb,
        dm_sh,
        dm_sw
    } dm_op_e;

    typedef enum logic [1:0] {
        mem_idle,
        mem_bus,
        mem_done
    } mem_state_e;

    // Decoded instruction as handed over by the issue stage.
    typedef struct packed {
        pc_t      pc_4;
        pc_t      pc_guessed;
        word_t    data_a;
        word_t    data_b;
        imm16_t   imm16;
        logic     use_imm;
        alu_op_e  alu_op;
        br_op_e   br_op;
        dm_op_e   dm_op;
        reg_idx_t reg_w;
        logic     reg_w_en;
        logic     syscall;
    } ex_issue_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc_4;
        word_t    alu_res;
        word_t    store_data;
        dm_op_e   dm_op;
        reg_idx_t reg_w;
        logic     reg_w_en;
        logic     syscall;
        logic     redirect;
        pc_t      redirect_pc;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t reg_w;
        logic     reg_w_en;
        word_t    data;
        logic     syscall;
    } wb_t;

endpackage

/* ex_mem_reg.sv */
`timescale 1ns/1ns

module ex_mem_reg import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en,
    input  logic      flush,
    input  logic      issue_fire,
    input  ex_issue_t issue,
    input  word_t     alu_res,
    input  logic      mispredict,
    input  pc_t       target_pc,
    output ex_mem_t   staged
);

    ex_mem_t staged_d;

    // Both execute results meet here in one record.
    assign staged_d = '{
        valid:       1'b1,
        pc_4:        issue.pc_4,
        alu_res:     alu_res,
        store_data:  issue.data_b,
        dm_op:       issue.dm_op,
        reg_w:       issue.reg_w,
        reg_w_en:    issue.reg_w_en,
        syscall:     issue.syscall,
        redirect:    mispredict,
        redirect_pc: target_pc
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            staged <= '0;
        end else if (flush) begin
            staged <= '0;
        end else if (en) begin
            if (issue_fire) begin
                staged <= staged_d;
            end else begin
                // Bubble.
                staged <= '0;
            end
        end
    end

    // A stalled record must survive until the memory stage releases it.
    assert property (@(posedge clk) disable iff (!rst_n)
        (!en && staged.valid && !flush) |=> $stable(staged))
        else $error("ex_mem_reg: stalled record changed");

endmodule

/* filelist.f */
core_pkg.sv
alu.sv
branch_unit.sv
ex_mem_reg.sv
mem_access.sv
core_backend.sv
tb_wb_memory.sv
tb_core_backend.sv

/* mem_access.sv */
`timescale 1ns/1ns

module mem_access import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  ex_mem_t    staged,
    output logic       busy,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output logic [3:0] wb_sel,
    output pc_t        wb_adr,
    output word_t      wb_dat_w,
    input  word_t      wb_dat_r,
    input  logic       wb_ack,
    output wb_t        wb_out
);

    mem_state_e state;
    mem_state_e state_nx;
    dm_op_e     op_q;
    logic [1:0] off_q;
    reg_idx_t   reg_w_q;
    logic       reg_w_en_q;
    logic       syscall_q;
    logic       staged_mem;
    logic       start;
    logic       wb_load;
    logic       wb_valid;
    reg_idx_t   wb_reg_w;
    logic       wb_reg_w_en;
    word_t      wb_data;
    logic       wb_syscall;

    function automatic logic [3:0] lane_sel(dm_op_e op, logic [1:0] off);
        case (op)
            dm_lb, dm_lbu, dm_sb: lane_sel = 4'b0001 << off;
            dm_lh, dm_lhu, dm_sh: lane_sel = off[1] ? 4'b1100 : 4'b0011;
            dm_lw, dm_sw:         lane_sel = 4'b1111;
            default:              lane_sel = 4'b0000;
        endcase
    endfunction

    function automatic word_t load_ext(dm_op_e op, logic [1:0] off, word_t raw);
        logic [7:0]  b;
        logic [15:0] h;
        b = raw[8*off +: 8];
        h = off[1] ? raw[31:16] : raw[15:0];
        case (op)
            dm_lb:   load_ext = {{24{b[7]}}, b};
            dm_lbu:  load_ext = {24'd0, b};
            dm_lh:   load_ext = {{16{h[15]}}, h};
            dm_lhu:  load_ext = {16'd0, h};
            dm_lw:   load_ext = raw;
            default: load_ext = '0;
        endcase
    endfunction

    assign staged_mem = staged.valid && (staged.dm_op != dm_none);
    assign start      = (state == mem_idle) && staged_mem;
    assign busy       = (state == mem_bus) || start;
    assign wb_load    = ((state == mem_idle) && staged.valid && !staged_mem) ||
                        ((state == mem_bus) && wb_ack);

    assign wb_cyc = (state == mem_bus);
    assign wb_stb = (state == mem_bus);

    always_comb begin
        state_nx = state;
        case (state)
            mem_idle: if (staged_mem) state_nx = mem_bus;
            mem_bus:  if (wb_ack) state_nx = mem_done;
            default:  state_nx = mem_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= mem_idle;
            wb_valid <= 1'b0;
        end else begin
            state    <= state_nx;
            wb_valid <= wb_load;
        end
    end

    // Request fields are captured once so a later flush cannot disturb the bus.
    always_ff @(posedge clk) begin
        if (start) begin
            op_q       <= staged.dm_op;
            off_q      <= staged.alu_res[1:0];
            reg_w_q    <= staged.reg_w;
            reg_w_en_q <= staged.reg_w_en;
            syscall_q  <= staged.syscall;
            wb_adr     <= {staged.alu_res[31:2], 2'b00};
            wb_sel     <= lane_sel(staged.dm_op, staged.alu_res[1:0]);
            wb_we      <= staged.dm_op inside {dm_sb, dm_sh, dm_sw};
            case (staged.dm_op)
                dm_sb:   wb_dat_w <= {4{staged.store_data[7:0]}};
                dm_sh:   wb_dat_w <= {2{staged.store_data[15:0]}};
                default: wb_dat_w <= staged.store_data;
            endcase
        end
        if (wb_load) begin
            if (state == mem_bus) begin
                wb_reg_w    <= reg_w_q;
                wb_reg_w_en <= reg_w_en_q && !wb_we;
                wb_data     <= load_ext(op_q, off_q, wb_dat_r);
                wb_syscall  <= syscall_q;
            end else begin
                wb_reg_w    <= staged.reg_w;
                wb_reg_w_en <= staged.reg_w_en;
                wb_data     <= staged.alu_res;
                wb_syscall  <= staged.syscall;
            end
        end
    end

    assign wb_out = '{
        valid:    wb_valid,
        reg_w:    wb_reg_w,
        reg_w_en: wb_reg_w_en,
        data:     wb_data,
        syscall:  wb_syscall
    };

    assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else $error("mem_access: stb without cyc");

    // Wishbone classic: the request holds until the slave acknowledges.
    assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> wb_stb && $stable(wb_adr) && $stable(wb_sel) &&
                                $stable(wb_we) && $stable(wb_dat_w))
        else $error("mem_access: request changed before ack");

endmodule

/* tb_core_backend.sv */
`timescale 1ns/1ns

module tb_core_backend import core_pkg::*; ();

    localparam int issue_timeout = 50;
    localparam int drain_timeout = 200;

    typedef struct packed {
        wb_t  wb;
        logic redirect;
        pc_t  redirect_pc;
    } expect_t;

    logic       clk;
    logic       rst_n;
    logic       issue_valid;
    ex_issue_t  issue;
    logic       issue_ready;
    logic       flush;
    logic       redirect;
    pc_t        redirect_pc;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [3:0] wb_sel;
    pc_t        wb_adr;
    word_t      wb_dat_w;
    word_t      wb_dat_r;
    logic       wb_ack;
    wb_t        wb_out;

    integer     seed = 31650;
    word_t      shadow [256];
    wb_t        exp_q [$];
    expect_t    mon_exp;
    logic       exp_redirect;
    pc_t        exp_redirect_pc;
    int         errors;
    int         checks;
    int         err_mark;
    int         tests_run;
    int         tests_failed;
    ex_issue_t  ins;
    alu_op_e    aop;
    br_op_e     bop;
    dm_op_e     dop;
    pc_t        addr;
    pc_t        next;
    word_t      data;

    core_backend core_backend_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .flush       (flush),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_sel      (wb_sel),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .wb_out      (wb_out)
    );

    tb_wb_memory tb_wb_memory_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (wb_cyc),
        .stb   (wb_stb),
        .we    (wb_we),
        .sel   (wb_sel),
        .adr   (wb_adr),
        .dat_w (wb_dat_w),
        .dat_r (wb_dat_r),
        .ack   (wb_ack)
    );

    always #10 clk = ~clk;

    function automatic word_t init_word(logic [7:0] i);
        return {i, ~i, i ^ 8'h5a, {i[3:0], i[7:4]} ^ 8'hc3};
    endfunction

    function automatic word_t random_word();
        return $random(seed);
    endfunction

    function automatic word_t alu_result(ex_issue_t in);
        word_t      b;
        logic [4:0] sh;
        if (!in.use_imm) begin
            b = in.data_b;
        end else if (in.alu_op inside {alu_and, alu_or, alu_xor}) begin
            b = {16'h0000, in.imm16};
        end else begin
            b = {{16{in.imm16[15]}}, in.imm16};
        end
        sh = in.imm16[10:6];
        case (in.alu_op)
            alu_add:  return in.data_a + b;
            alu_sub:  return in.data_a - b;
            alu_and:  return in.data_a & b;
            alu_or:   return in.data_a | b;
            alu_xor:  return in.data_a ^ b;
            alu_slt:  return ($signed(in.data_a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (in.data_a < b) ? 32'd1 : 32'd0;
            alu_sll:  return in.data_b << sh;
            alu_srl:  return in.data_b >> sh;
            alu_sra:  return word_t'($signed(in.data_b) >>> sh);
            alu_lui:  return {in.imm16, 16'h0000};
            default:  return '0;
        endcase
    endfunction

    function automatic pc_t real_next_pc(ex_issue_t in);
        pc_t off;
        off = {{14{in.imm16[15]}}, in.imm16, 2'b00};
        case (in.br_op)
            br_beq:  return (in.data_a == in.data_b) ? in.pc_4 + off : in.pc_4;
            br_bne:  return (in.data_a != in.data_b) ? in.pc_4 + off : in.pc_4;
            br_blez: return ($signed(in.data_a) <= 0) ? in.pc_4 + off : in.pc_4;
            br_bgtz: return ($signed(in.data_a) > 0) ? in.pc_4 + off : in.pc_4;
            br_j:    return {in.pc_4[31:28], 28'({in.imm16, 2'b00})};
            br_jr:   return in.data_a;
            default: return in.pc_4;
        endcase
    endfunction

    // Expected writeback and redirect, with loads served from the shadow memory.
    function automatic expect_t expected_result(ex_issue_t in);
        expect_t    e;
        word_t      res;
        word_t      word;
        logic [1:0] off;
        logic [7:0] lane_byte;
        logic [15:0] lane_half;
        res           = alu_result(in);
        e.redirect_pc = real_next_pc(in);
        e.redirect    = (e.redirect_pc != in.pc_guessed);
        e.wb.valid    = 1'b1;
        e.wb.reg_w    = in.reg_w;
        e.wb.reg_w_en = in.reg_w_en;
        e.wb.syscall  = in.syscall;
        e.wb.data     = res;
        off       = res[1:0];
        word      = shadow[res[9:2]];
        lane_byte = 8'(word >> (8 * off));
        lane_half = off[1] ? word[31:16] : word[15:0];
        case (in.dm_op)
            dm_lb:  e.wb.data = {{24{lane_byte[7]}}, lane_byte};
            dm_lbu: e.wb.data = {24'd0, lane_byte};
            dm_lh:  e.wb.data = {{16{lane_half[15]}}, lane_half};
            dm_lhu: e.wb.data = {16'd0, lane_half};
            dm_lw:  e.wb.data = word;
            dm_sb, dm_sh, dm_sw: e.wb.reg_w_en = 1'b0;
            default: e.wb.data = res;
        endcase
        return e;
    endfunction

    task automatic apply_store(input ex_issue_t in);
        word_t      a;
        logic [1:0] off;
        a   = alu_result(in);
        off = a[1:0];
        case (in.dm_op)
            dm_sb:   shadow[a[9:2]][8*off +: 8] = in.data_b[7:0];
            dm_sh:   shadow[a[9:2]][16*off[1] +: 16] = in.data_b[15:0];
            dm_sw:   shadow[a[9:2]] = in.data_b;
            default: ;
        endcase
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        checks++;
        if (got.reg_w !== exp.reg_w || got.reg_w_en !== exp.reg_w_en ||
            got.syscall !== exp.syscall || (exp.reg_w_en && got.data !== exp.data)) begin
            errors++;
            $display("Mismatch at %0t: writeback r%0d en=%0b data=%h sys=%0b", $time,
                     got.reg_w, got.reg_w_en, got.data, got.syscall);
            $display("    expected r%0d en=%0b data=%h sys=%0b",
                     exp.reg_w, exp.reg_w_en, exp.data, exp.syscall);
        end
    endtask

    task automatic check_redirect(input logic got_flag, input pc_t got_pc,
                                  input logic exp_flag, input pc_t exp_pc);
        checks++;
        if (got_flag !== exp_flag || (exp_flag && got_pc !== exp_pc)) begin
            errors++;
            $display("Mismatch at %0t: redirect=%0b pc=%h, expected redirect=%0b pc=%h",
                     $time, got_flag, got_pc, exp_flag, exp_pc);
        end
    endtask

    task automatic check_idle_outputs();
        checks++;
        if (wb_cyc || wb_stb || wb_out.valid || redirect || !issue_ready) begin
            errors++;
            $display("Outputs not idle around reset at %0t: cyc=%0b stb=%0b wb=%0b", $time,
                     wb_cyc, wb_stb, wb_out.valid);
            $display("    redirect=%0b issue_ready=%0b", redirect, issue_ready);
        end
    endtask

    // Scoreboard. Expectations are formed in the cycle an instruction is accepted.
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_redirect    = 1'b0;
            exp_redirect_pc = '0;
        end else begin
            check_redirect(redirect, redirect_pc, exp_redirect, exp_redirect_pc);
            if (wb_out.valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected writeback to r%0d at %0t with nothing outstanding",
                             wb_out.reg_w, $time);
                end else begin
                    check_wb(wb_out, exp_q.pop_front());
                end
            end
            if (flush) begin
                exp_redirect = 1'b0;
            end else if (issue_ready) begin
                if (issue_valid) begin
                    mon_exp = expected_result(issue);
                    exp_q.push_back(mon_exp.wb);
                    apply_store(issue);
                    exp_redirect    = mon_exp.redirect;
                    exp_redirect_pc = mon_exp.redirect_pc;
                end else begin
                    exp_redirect = 1'b0;
                end
            end
        end
    end

    // Called 2 ns after a rising edge, returns 2 ns after the accepting edge.
    task automatic issue_instr(input ex_issue_t in);
        int waited;
        waited      = 0;
        issue       = in;
        issue_valid = 1'b1;
        @(negedge clk);
        while (!issue_ready && waited < issue_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!issue_ready) begin
            errors++;
            $display("Timeout at %0t: issue_ready stayed low for %0d cycles", $time, waited);
        end
        @(posedge clk);
        #2;
        issue_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timeout at %0t: %0d writebacks never arrived", $time, exp_q.size());
            exp_q.delete();
        end
        @(posedge clk);
        #2;
    endtask

    function automatic ex_issue_t base_instr();
        ex_issue_t in;
        in            = '0;
        in.pc_4       = random_word() & 32'hffff_fffc;
        in.pc_guessed = in.pc_4;
        in.alu_op     = alu_add;
        in.br_op      = br_none;
        in.dm_op      = dm_none;
        in.reg_w      = reg_idx_t'(random_word());
        in.reg_w_en   = 1'b1;
        return in;
    endfunction

    // Base register sits 8 above the address so the negative offset is exercised.
    function automatic ex_issue_t mem_instr(dm_op_e op, pc_t a, word_t d);
        ex_issue_t in;
        in         = base_instr();
        in.dm_op   = op;
        in.use_imm = 1'b1;
        in.data_a  = a + 32'd8;
        in.imm16   = 16'hfff8;
        in.data_b  = d;
        return in;
    endfunction

    task automatic begin_test();
        err_mark = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - err_mark);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue        = '0;
        flush        = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = init_word(i[7:0]);
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        begin_test();
        aop = aop.first();
        repeat (aop.num()) begin
            repeat (3) begin
                ins         = base_instr();
                ins.alu_op  = aop;
                ins.data_a  = random_word();
                ins.data_b  = random_word();
                ins.imm16   = imm16_t'(random_word());
                ins.use_imm = (random_word() % 2) == 1;
                ins.syscall = (random_word() % 8) == 0;
                issue_instr(ins);
            end
            aop = aop.next();
        end
        drain();
        end_test("alu operations");

        begin_test();
        bop = bop.first();
        repeat (bop.num()) begin
            for (int k = 0; k < 4; k++) begin
                ins          = base_instr();
                ins.br_op    = bop;
                ins.reg_w_en = 1'b0;
                ins.imm16    = imm16_t'(random_word());
                case (k)
                    0:       ins.data_a = 32'hffff_ffff;
                    1:       ins.data_a = 32'h0000_0000;
                    2:       ins.data_a = (random_word() & 32'h7fff_fff0) | 32'h4;
                    default: ins.data_a = random_word();
                endcase
                ins.data_b = k[0] ? ins.data_a : random_word();
                next       = real_next_pc(ins);
                case (k)
                    0:       ins.pc_guessed = next;
                    1:       ins.pc_guessed = ins.pc_4;
                    2:       ins.pc_guessed = next + 32'd4;
                    default: ins.pc_guessed = random_word() & 32'hffff_fffc;
                endcase
                issue_instr(ins);
            end
            bop = bop.next();
        end
        drain();
        end_test("branches");

        begin_test();
        for (int off = 0; off < 4; off++) begin
            addr    = 32'h200 + off;
            data    = random_word();
            data[7] = off[0];
            issue_instr(mem_instr(dm_sb, addr, data));
            issue_instr(mem_instr(dm_lb, addr, '0));
            issue_instr(mem_instr(dm_lbu, addr, '0));
        end
        for (int off = 0; off < 4; off += 2) begin
            addr     = 32'h204 + off;
            data     = random_word();
            data[15] = off[1];
            issue_instr(mem_instr(dm_sh, addr, data));
            issue_instr(mem_instr(dm_lh, addr, '0));
            issue_instr(mem_instr(dm_lhu, addr, '0));
        end
        issue_instr(mem_instr(dm_sw, 32'h208, random_word()));
        issue_instr(mem_instr(dm_lw, 32'h208, '0));
        issue_instr(mem_instr(dm_lw, 32'h200, '0));
        issue_instr(mem_instr(dm_lw, 32'h204, '0));
        issue_instr(mem_instr(dm_lw, 32'h3f0, '0));
        drain();
        end_test("loads and stores");

        begin_test();
        repeat (60) begin
            if (random_word() % 2 == 0) begin
                ins         = base_instr();
                ins.alu_op  = alu_op_e'(random_word() % 11);
                ins.data_a  = random_word();
                ins.data_b  = random_word();
                ins.imm16   = imm16_t'(random_word());
                ins.use_imm = (random_word() % 2) == 1;
                issue_instr(ins);
            end else begin
                dop  = dm_op_e'(1 + random_word() % 8);
                addr = 32'h300 | (random_word() & 32'hff);
                if (dop inside {dm_lh, dm_lhu, dm_sh}) begin
                    addr[0] = 1'b0;
                end
                if (dop inside {dm_lw, dm_sw}) begin
                    addr[1:0] = 2'b00;
                end
                issue_instr(mem_instr(dop, addr, random_word()));
                @(negedge clk);
                checks++;
                if (issue_ready) begin
                    errors++;
                    $display("issue_ready stayed high during a memory access at %0t", $time);
                end
                @(posedge clk);
                #2;
            end
            if (random_word() % 4 == 0) begin
                @(posedge clk);
                #2;
            end
        end
        drain();
        end_test("back-pressure");

        begin_test();
        issue_instr(base_instr());
        ins          = base_instr();
        ins.br_op    = br_j;
        ins.imm16    = imm16_t'(random_word()) | 16'h0001;
        ins.reg_w_en = 1'b1;
        flush        = 1'b1;
        issue_instr(ins);
        flush = 1'b0;
        // Window in which a dropped instruction would show up.
        repeat (6) @(posedge clk);
        #2;
        repeat (4) begin
            issue_instr(base_instr());
        end
        issue_instr(mem_instr(dm_lw, 32'h208, '0));
        drain();
        end_test("flush");

        begin_test();
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_idle_outputs();
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        @(posedge clk);
        #2;
        issue_instr(base_instr());
        issue_instr(mem_instr(dm_lbu, 32'h201, '0));
        drain();
        end_test("reset");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb_wb_memory.sv */
`timescale 1ns/1ns

module tb_wb_memory import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  logic [3:0] sel,
    input  pc_t        adr,
    input  word_t      dat_w,
    output word_t      dat_r,
    output logic       ack
);

    word_t      mem [256];
    integer     seed = 31650;
    logic       active;
    logic [1:0] wait_cnt;
    logic [1:0] draw;
    logic       serve;
    logic [7:0] idx;

    // 1 KB, word addressed.
    assign idx = adr[9:2];

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, {i[3:0], i[7:4]} ^ 8'hc3};
        end
    end

    // Each request draws an extra wait of 0 to 3 cycles before ack.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack      <= 1'b0;
            active   <= 1'b0;
            wait_cnt <= 2'd0;
            dat_r    <= '0;
        end else begin
            ack   <= 1'b0;
            serve = 1'b0;
            if (cyc && stb && !ack) begin
                if (!active) begin
                    draw = 2'($random(seed));
                    if (draw == 2'd0) begin
                        serve = 1'b1;
                    end else begin
                        active   <= 1'b1;
                        wait_cnt <= draw - 2'd1;
                    end
                end else if (wait_cnt == 2'd0) begin
                    serve  = 1'b1;
                    active <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
            if (serve) begin
                ack   <= 1'b1;
                dat_r <= mem[idx];
                if (we) begin
                    for (int k = 0; k < 4; k++) begin
                        if (sel[k]) begin
                            mem[idx][8*k +: 8] <= dat_w[8*k +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule
